/* Bender.yml */
package:
  name: cnn_quad

sources:
  - src/cnn_quad_pkg.sv
  - src/ce_issue_if.sv
  - src/quad_ctrl.sv
  - src/prefetch_buffer.sv
  - src/weight_table.sv
  - src/compute_engine.sv
  - src/cnn_quad_top.sv
  - target: test
    files:
      - tests/cnn_quad_assert.sv
      - tests/cnn_quad_tb.sv

/* project.f */
src/cnn_quad_pkg.sv
src/ce_issue_if.sv
src/quad_ctrl.sv
src/prefetch_buffer.sv
src/weight_table.sv
src/compute_engine.sv
src/cnn_quad_top.sv
tests/cnn_quad_assert.sv
tests/cnn_quad_tb.sv

/* src/ce_issue_if.sv */
`timescale 1ns/100ps

// Each issue strobe carries one compute item without a handshake
interface ce_issue_if
    import cnn_quad_pkg::*;
();

    logic                         issue;
    logic [COL_ADDR_WIDTH-1:0]    col;
    logic [KERNEL_ADDR_WIDTH-1:0] kernel;
    logic                         relu_en;

    modport ctrl (
        output issue,
        output col,
        output kernel,
        output relu_en
    );

    modport pfb (input issue, input col);

    modport wht (input issue, input kernel);

    modport ce (input issue, input relu_en);

endinterface

/* src/cnn_quad_pkg.sv */
package cnn_quad_pkg;

    ////////////////////
    // Data widths
    ////////////////////
    localparam int PIXEL_WIDTH       = 8;
    localparam int WEIGHT_WIDTH      = 8;
    localparam int KERNEL_TAPS       = 3;
    localparam int PRODUCT_WIDTH     = PIXEL_WIDTH + WEIGHT_WIDTH;
    localparam int RESULT_WIDTH      = 16;
    localparam int WEIGHT_WORD_WIDTH = KERNEL_TAPS * WEIGHT_WIDTH;

    ////////////////////
    // Depths and counters
    ////////////////////
    localparam int MAX_COLS          = 32;
    localparam int COL_ADDR_WIDTH    = 5;
    localparam int MAX_KERNELS       = 8;
    localparam int KERNEL_ADDR_WIDTH = 3;
    localparam int ROW_COUNT_WIDTH   = 6;

    // Enough for 63 rows of 8 kernels by 30 columns
    localparam int RESULT_COUNT_WIDTH = 14;

    // Job parameter word as sent by the host
    typedef struct packed {
        logic                         reserved;
        logic                         relu_en;
        logic [ROW_COUNT_WIDTH-1:0]   num_output_rows;
        logic [KERNEL_ADDR_WIDTH-1:0] num_kernels_m1;
        logic [COL_ADDR_WIDTH-1:0]    num_output_cols;
    } job_params_t;

    typedef enum logic [2:0] {
        IDLE,
        FETCH_ROW,
        LOAD_ROW,
        COMPUTE,
        WAIT_DRAIN,
        SEND_COMPLETE
    } ctrl_state_e;

endpackage

/* src/cnn_quad_top.sv */
`timescale 1ns/100ps

module cnn_quad_top
    import cnn_quad_pkg::*;
(
    input  logic                           clk_core,
    input  logic                           rst,

    // Job and fetch handshake
    input  logic                           job_start,
    output logic                           job_accept,
    input  logic [$bits(job_params_t)-1:0] job_parameters,
    output logic                           job_fetch_request,
    input  logic                           job_fetch_ack,
    input  logic                           job_fetch_complete,
    output logic                           job_complete,
    input  logic                           job_complete_ack,

    // Pixel row stream
    input  logic                           pixel_valid,
    output logic                           pixel_ready,
    input  logic [PIXEL_WIDTH-1:0]         pixel_data,

    // Kernel weights with one kernel per beat
    input  logic                           weight_valid,
    output logic                           weight_ready,
    input  logic [WEIGHT_WORD_WIDTH-1:0]   weight_data,

    output logic                           result_valid,
    output logic [RESULT_WIDTH-1:0]        result_data
);

    logic                                     row_start;
    logic [KERNEL_TAPS-1:0][PIXEL_WIDTH-1:0]  window;
    logic [KERNEL_TAPS-1:0][WEIGHT_WIDTH-1:0] weights;

    ce_issue_if issue_bus ();

    quad_ctrl i0_quad_ctrl (
        .clk_core           (clk_core),
        .rst                (rst),
        .job_start          (job_start),
        .job_parameters     (job_params_t'(job_parameters)),
        .job_fetch_ack      (job_fetch_ack),
        .job_fetch_complete (job_fetch_complete),
        .job_complete_ack   (job_complete_ack),
        .result_valid       (result_valid),
        .job_accept         (job_accept),
        .job_fetch_request  (job_fetch_request),
        .pixel_ready        (pixel_ready),
        .job_complete       (job_complete),
        .weight_ready       (weight_ready),
        .row_start          (row_start),
        .issue              (issue_bus.ctrl)
    );

    prefetch_buffer i0_prefetch_buffer (
        .clk_core    (clk_core),
        .rst         (rst),
        .row_start   (row_start),
        .pixel_valid (pixel_valid),
        .pixel_ready (pixel_ready),
        .pixel_data  (pixel_data),
        .issue       (issue_bus.pfb),
        .window      (window)
    );

    weight_table i0_weight_table (
        .clk_core         (clk_core),
        .rst              (rst),
        .weight_valid     (weight_valid),
        .weight_ready     (weight_ready),
        .weight_data      (weight_data),
        .job_complete_ack (job_complete_ack),
        .issue            (issue_bus.wht),
        .weights          (weights)
    );

    compute_engine i0_compute_engine (
        .clk_core     (clk_core),
        .rst          (rst),
        .window       (window),
        .weights      (weights),
        .issue        (issue_bus.ce),
        .result_valid (result_valid),
        .result_data  (result_data)
    );

endmodule

/* src/compute_engine.sv */
`timescale 1ns/100ps

module compute_engine
    import cnn_quad_pkg::*;
(
    input  logic                                    clk_core,
    input  logic                                    rst,
    input  logic [KERNEL_TAPS-1:0][PIXEL_WIDTH-1:0] window,
    input  logic [KERNEL_TAPS-1:0][WEIGHT_WIDTH-1:0] weights,
    ce_issue_if.ce                                  issue,
    output logic                                    result_valid,
    output logic [RESULT_WIDTH-1:0]                 result_data
);

    logic                            issue_d1;
    logic                            relu_d1;
    logic                            prod_valid;
    logic signed [PIXEL_WIDTH-1:0]   act [KERNEL_TAPS];
    logic signed [PRODUCT_WIDTH-1:0] prod [KERNEL_TAPS];
    logic signed [RESULT_WIDTH-1:0]  prod_sum;

    ////////////////////
    // Stage 1 operands
    ////////////////////

    // Line up with the registered window and weights
    always_ff @(posedge clk_core) begin
        if (rst) begin
            issue_d1 <= 1'b0;
        end else begin
            issue_d1 <= issue.issue;
        end
    end

    always_ff @(posedge clk_core) begin
        relu_d1 <= issue.relu_en;
    end

    // ReLU clamps negative pixels
    always_comb begin
        for (int t = 0; t < KERNEL_TAPS; t++) begin
            if (relu_d1 && window[t][PIXEL_WIDTH-1]) begin
                act[t] = '0;
            end else begin
                act[t] = $signed(window[t]);
            end
        end
    end

    ////////////////////
    // Stage 2 products
    ////////////////////

    always_ff @(posedge clk_core) begin
        if (rst) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= issue_d1;
        end
    end

    always_ff @(posedge clk_core) begin
        if (issue_d1) begin
            for (int t = 0; t < KERNEL_TAPS; t++) begin
                prod[t] <= act[t] * $signed(weights[t]);
            end
        end
    end

    ////////////////////
    // Stage 3 sum
    ////////////////////

    // Wraps in two's complement at RESULT_WIDTH
    always_comb begin
        prod_sum = '0;
        for (int t = 0; t < KERNEL_TAPS; t++) begin
            prod_sum = prod_sum + RESULT_WIDTH'(prod[t]);
        end
    end

    always_ff @(posedge clk_core) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= prod_valid;
        end
    end

    always_ff @(posedge clk_core) begin
        if (prod_valid) begin
            result_data <= prod_sum;
        end
    end

endmodule

/* src/prefetch_buffer.sv */
`timescale 1ns/100ps

module prefetch_buffer
    import cnn_quad_pkg::*;
(
    input  logic                                    clk_core,
    input  logic                                    rst,
    input  logic                                    row_start,
    input  logic                                    pixel_valid,
    input  logic                                    pixel_ready,
    input  logic [PIXEL_WIDTH-1:0]                  pixel_data,
    ce_issue_if.pfb                                 issue,
    output logic [KERNEL_TAPS-1:0][PIXEL_WIDTH-1:0] window
);

    logic [PIXEL_WIDTH-1:0]    row_mem [MAX_COLS];
    logic [COL_ADDR_WIDTH-1:0] wr_addr;
    logic                      wr_en;

    assign wr_en = pixel_valid && pixel_ready;

    // Write pointer for the row being fetched
    always_ff @(posedge clk_core) begin
        if (rst || row_start) begin
            wr_addr <= '0;
        end else if (wr_en) begin
            wr_addr <= wr_addr + 1'b1;
        end
    end

    always_ff @(posedge clk_core) begin
        if (wr_en) begin
            row_mem[wr_addr] <= pixel_data;
        end
    end

    // Three neighbouring pixels starting at the issued column
    always_ff @(posedge clk_core) begin
        if (issue.issue) begin
            for (int t = 0; t < KERNEL_TAPS; t++) begin
                window[t] <= row_mem[issue.col + COL_ADDR_WIDTH'(t)];
            end
        end
    end

endmodule

/* src/quad_ctrl.sv */
`timescale 1ns/100ps

module quad_ctrl
    import cnn_quad_pkg::*;
(
    input  logic        clk_core,
    input  logic        rst,
    input  logic        job_start,
    input  job_params_t job_parameters,
    input  logic        job_fetch_ack,
    input  logic        job_fetch_complete,
    input  logic        job_complete_ack,
    input  logic        result_valid,
    output logic        job_accept,
    output logic        job_fetch_request,
    output logic        pixel_ready,
    output logic        job_complete,
    output logic        weight_ready,
    output logic        row_start,
    ce_issue_if.ctrl    issue
);

    ctrl_state_e                   state;
    job_params_t                   job_params;
    logic                          job_taken;
    logic [COL_ADDR_WIDTH-1:0]     col_cnt;
    logic [KERNEL_ADDR_WIDTH-1:0]  kernel_cnt;
    logic [ROW_COUNT_WIDTH-1:0]    row_cnt;
    logic [RESULT_COUNT_WIDTH-1:0] result_cnt;
    logic [RESULT_COUNT_WIDTH-1:0] total_results;
    logic [KERNEL_ADDR_WIDTH:0]    num_kernels;
    logic                          last_col;
    logic                          last_kernel;
    logic                          last_row;

    ////////////////////
    // Host side levels
    ////////////////////

    assign job_fetch_request = (state == FETCH_ROW);
    assign pixel_ready       = (state == LOAD_ROW);
    assign job_complete      = (state == SEND_COMPLETE);
    assign weight_ready      = (state == IDLE);

    // Buffer write address restarts here
    assign row_start = job_fetch_request && job_fetch_ack;

    assign job_taken = (state == IDLE) && job_start;

    ////////////////////
    // Issue generation
    ////////////////////

    assign issue.issue   = (state == COMPUTE);
    assign issue.col     = col_cnt;
    assign issue.kernel  = kernel_cnt;
    assign issue.relu_en = job_params.relu_en;

    assign last_col    = (col_cnt == job_params.num_output_cols - 1'b1);
    assign last_kernel = (kernel_cnt == job_params.num_kernels_m1);
    assign last_row    = (row_cnt == job_params.num_output_rows - 1'b1);

    // Expected result count for the whole job
    assign num_kernels   = {1'b0, job_params.num_kernels_m1} + 1'b1;
    assign total_results = RESULT_COUNT_WIDTH'(job_params.num_output_rows)
                         * RESULT_COUNT_WIDTH'(num_kernels)
                         * RESULT_COUNT_WIDTH'(job_params.num_output_cols);

    always_ff @(posedge clk_core) begin
        if (job_taken) begin
            job_params <= job_parameters;
        end
    end

    ////////////////////
    // Job FSM
    ////////////////////

    always_ff @(posedge clk_core) begin
        if (rst) begin
            state      <= IDLE;
            job_accept <= 1'b0;
            col_cnt    <= '0;
            kernel_cnt <= '0;
            row_cnt    <= '0;
        end else begin
            job_accept <= 1'b0;
            case (state)
                IDLE: begin
                    if (job_start) begin
                        job_accept <= 1'b1;
                        row_cnt    <= '0;
                        state      <= FETCH_ROW;
                    end
                end
                FETCH_ROW: begin
                    if (job_fetch_ack) begin
                        state <= LOAD_ROW;
                    end
                end
                LOAD_ROW: begin
                    if (job_fetch_complete) begin
                        state <= COMPUTE;
                    end
                end
                COMPUTE: begin
                    // Column innermost, then kernel
                    if (last_col) begin
                        col_cnt <= '0;
                        if (last_kernel) begin
                            kernel_cnt <= '0;
                            row_cnt    <= row_cnt + 1'b1;
                            state      <= last_row ? WAIT_DRAIN : FETCH_ROW;
                        end else begin
                            kernel_cnt <= kernel_cnt + 1'b1;
                        end
                    end else begin
                        col_cnt <= col_cnt + 1'b1;
                    end
                end
                WAIT_DRAIN: begin
                    // Pipeline empty once every result is back
                    if (result_cnt == total_results) begin
                        state <= SEND_COMPLETE;
                    end
                end
                SEND_COMPLETE: begin
                    if (job_complete_ack) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    ////////////////////
    // Result tracking
    ////////////////////

    always_ff @(posedge clk_core) begin
        if (rst) begin
            result_cnt <= '0;
        end else if (job_taken) begin
            result_cnt <= '0;
        end else if (result_valid) begin
            result_cnt <= result_cnt + 1'b1;
        end
    end

endmodule

/* src/weight_table.sv */
`timescale 1ns/100ps

module weight_table
    import cnn_quad_pkg::*;
(
    input  logic                                     clk_core,
    input  logic                                     rst,
    input  logic                                     weight_valid,
    input  logic                                     weight_ready,
    input  logic [WEIGHT_WORD_WIDTH-1:0]             weight_data,
    input  logic                                     job_complete_ack,
    ce_issue_if.wht                                  issue,
    output logic [KERNEL_TAPS-1:0][WEIGHT_WIDTH-1:0] weights
);

    logic [WEIGHT_WORD_WIDTH-1:0] kernel_mem [MAX_KERNELS];
    logic [KERNEL_ADDR_WIDTH-1:0] wr_ptr;
    logic                         wr_en;

    assign wr_en = weight_valid && weight_ready;

    // Next job starts loading from entry zero
    always_ff @(posedge clk_core) begin
        if (rst || job_complete_ack) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk_core) begin
        if (wr_en) begin
            kernel_mem[wr_ptr] <= weight_data;
        end
    end

    // Tap 0 sits in the low byte of each entry
    always_ff @(posedge clk_core) begin
        if (issue.issue) begin
            weights <= kernel_mem[issue.kernel];
        end
    end

endmodule

/* tests/cnn_quad_assert.sv */
`timescale 1ns/100ps

module cnn_quad_assert
    import cnn_quad_pkg::*;
(
    input logic        clk_core,
    input logic        rst,
    input ctrl_state_e state,
    input logic        job_fetch_request,
    input logic        job_fetch_ack,
    input logic        pixel_ready,
    input logic        job_complete,
    input logic        job_complete_ack,
    input logic        issue_valid
);

    // Request drops once the ack is taken
    a_fetch_request_drop: assert property (@(posedge clk_core) disable iff (rst)
        job_fetch_request && job_fetch_ack |=> !job_fetch_request)
        else $error("job_fetch_request still high after job_fetch_ack");

    a_ready_vs_request: assert property (@(posedge clk_core) disable iff (rst)
        !(pixel_ready && job_fetch_request))
        else $error("pixel_ready and job_fetch_request high together");

    a_complete_held: assert property (@(posedge clk_core) disable iff (rst)
        job_complete && !job_complete_ack |=> job_complete)
        else $error("job_complete dropped without job_complete_ack");

    a_issue_in_compute: assert property (@(posedge clk_core) disable iff (rst)
        issue_valid |-> state == COMPUTE)
        else $error("issue outside the COMPUTE state");

endmodule

bind quad_ctrl cnn_quad_assert i0_cnn_quad_assert (
    .clk_core          (clk_core),
    .rst               (rst),
    .state             (state),
    .job_fetch_request (job_fetch_request),
    .job_fetch_ack     (job_fetch_ack),
    .pixel_ready       (pixel_ready),
    .job_complete      (job_complete),
    .job_complete_ack  (job_complete_ack),
    .issue_valid       (issue.issue)
);

/* tests/cnn_quad_stimulus.txt */
// Hex words in order: job count, then per job the parameter word, one weight word per kernel
// (tap 0 in the low byte), cols+2 pixels per row, expected results in row, kernel, column order
3

// Job 0: 1 row, 1 kernel, 4 columns, no ReLU
0104
FF0201
03 FE 05 07 FC 01
FFFA 0001 0017 FFFE

// Job 1: ReLU on with negative pixels, 1 row, 2 kernels, 3 columns
4123
04FD02
0AFFFF
FB 06 F9 08 09
FFEE 002C 000C
FFFA 004A 0052

// Job 2: 2 rows, 2 kernels, 3 columns, first sum wraps past 16 bits
0223
646464
000180
7F 7F 7F 80 00
01 02 03 04 05
94D4 3138 FF9C
C0FF C0FF C000
0258 0384 04B0
FF82 FF03 FE84

/* tests/cnn_quad_tb.sv */
`timescale 1ns/100ps

module cnn_quad_tb
    import cnn_quad_pkg::*;
();

    localparam int          CLK_PERIOD = 8;
    localparam int          WAIT_LIMIT = 2000;
    localparam logic [31:0] LFSR_SEED  = 32'h42f52694;
    localparam logic [31:0] LFSR_TAPS  = 32'h80200003;

    logic                         clk_core           = 1'b0;
    logic                         rst                = 1'b1;
    logic                         job_start          = 1'b0;
    logic [15:0]                  job_parameters     = '0;
    logic                         job_fetch_ack      = 1'b0;
    logic                         job_fetch_complete = 1'b0;
    logic                         job_complete_ack   = 1'b0;
    logic                         pixel_valid        = 1'b0;
    logic [PIXEL_WIDTH-1:0]       pixel_data         = '0;
    logic                         weight_valid       = 1'b0;
    logic [WEIGHT_WORD_WIDTH-1:0] weight_data        = '0;
    logic                         job_accept;
    logic                         job_fetch_request;
    logic                         job_complete;
    logic                         pixel_ready;
    logic                         weight_ready;
    logic                         result_valid;
    logic [RESULT_WIDTH-1:0]      result_data;

    logic [23:0]             stim [256];
    logic [RESULT_WIDTH-1:0] results [$];
    logic [31:0]             lfsr_state   = LFSR_SEED;
    logic                    fetch_window = 1'b0;
    int                      ptr;
    int                      num_jobs;
    int                      value_errors    = 0;
    int                      protocol_errors = 0;
    int                      timeouts        = 0;

    cnn_quad_top uut (.*);

    always #(CLK_PERIOD / 2) clk_core = ~clk_core;

    // Galois form stepped once per bit
    function automatic logic next_random_bit();
        logic out_bit;
        out_bit    = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ LFSR_TAPS;
        end
        return out_bit;
    endfunction

    task automatic report_timeout(input string what);
        timeouts++;
        $display("Timed out at %0t waiting for %s", $time, what);
    endtask

    //////////////////////
    // Output monitor
    //////////////////////

    always @(posedge clk_core) begin
        if (!rst) begin
            if (result_valid) begin
                results.push_back(result_data);
                assert (!job_complete) else begin
                    protocol_errors++;
                    $display("A result arrived at %0t after job_complete was raised", $time);
                end
            end
            // Ready only inside the ack to complete window
            assert (!pixel_ready || fetch_window) else begin
                protocol_errors++;
                $display("pixel_ready was high outside a row fetch at %0t", $time);
            end
        end
    end

    //////////////////////
    // Host model
    //////////////////////

    task automatic run_job(input int job_idx, input logic gaps);
        job_params_t prm;
        int          nk;
        int          pbase;
        int          ebase;
        int          total;
        int          waited;
        int          sent;
        logic        seen;
        prm   = job_params_t'(stim[ptr][15:0]);
        nk    = prm.num_kernels_m1 + 1;
        pbase = ptr + 1 + nk;
        ebase = pbase + prm.num_output_rows * (prm.num_output_cols + 2);
        total = prm.num_output_rows * nk * prm.num_output_cols;
        results.delete();

        // Weights go in while the quad is idle
        for (int k = 0; k < nk; k++) begin
            weight_valid <= 1'b1;
            weight_data  <= stim[ptr + 1 + k];
            seen   = 1'b0;
            waited = 0;
            while (!seen && waited < WAIT_LIMIT) begin
                @(posedge clk_core);
                seen = weight_valid && weight_ready;
                waited++;
            end
            if (!seen) report_timeout("weight_ready");
        end
        weight_valid <= 1'b0;
        ptr = ebase + total;

        job_start      <= 1'b1;
        job_parameters <= prm;
        seen   = 1'b0;
        waited = 0;
        while (!seen && waited < WAIT_LIMIT) begin
            @(posedge clk_core);
            seen = job_accept;
            waited++;
        end
        job_start <= 1'b0;
        if (!seen) report_timeout("job_accept");

        for (int r = 0; r < prm.num_output_rows; r++) begin
            seen   = 1'b0;
            waited = 0;
            while (!seen && waited < WAIT_LIMIT) begin
                @(posedge clk_core);
                seen = job_fetch_request;
                waited++;
            end
            if (!seen) report_timeout("job_fetch_request");
            job_fetch_ack <= 1'b1;
            fetch_window  <= 1'b1;
            @(posedge clk_core);
            job_fetch_ack <= 1'b0;
            sent   = 0;
            waited = 0;
            while (sent < prm.num_output_cols + 2 && waited < WAIT_LIMIT) begin
                pixel_valid <= gaps ? next_random_bit() : 1'b1;
                pixel_data  <= stim[pbase + sent][PIXEL_WIDTH-1:0];
                @(posedge clk_core);
                if (pixel_valid && pixel_ready) begin
                    sent++;
                end
                waited++;
            end
            if (sent < prm.num_output_cols + 2) report_timeout("pixel_ready");
            pixel_valid        <= 1'b0;
            job_fetch_complete <= 1'b1;
            @(posedge clk_core);
            job_fetch_complete <= 1'b0;
            fetch_window       <= 1'b0;
            pbase = pbase + prm.num_output_cols + 2;
        end

        seen   = 1'b0;
        waited = 0;
        while (!seen && waited < WAIT_LIMIT) begin
            @(posedge clk_core);
            seen = job_complete;
            waited++;
        end
        if (!seen) report_timeout("job_complete");

        // Acknowledge comes late so the level has to hold
        repeat (3) begin
            @(posedge clk_core);
            assert (job_complete) else begin
                protocol_errors++;
                $display("job_complete dropped before its acknowledge at %0t", $time);
            end
        end
        job_complete_ack <= 1'b1;
        @(posedge clk_core);
        job_complete_ack <= 1'b0;

        assert (results.size() == total) else begin
            value_errors++;
            $display("[FAIL] %0t: job %0d returned %0d results, expected %0d",
                     $time, job_idx, results.size(), total);
        end
        for (int i = 0; i < total && i < results.size(); i++) begin
            assert (results[i] == stim[ebase + i][RESULT_WIDTH-1:0]) else begin
                value_errors++;
                $display("[FAIL] %0t: job %0d result %0d is %h, expected %h",
                         $time, job_idx, i, results[i], stim[ebase + i][RESULT_WIDTH-1:0]);
            end
        end
    endtask

    initial begin
        $readmemh("tests/cnn_quad_stimulus.txt", stim);
        repeat (5) @(posedge clk_core);
        rst <= 1'b0;
        @(posedge clk_core);
        assert (!job_accept && !job_fetch_request && !job_complete && !pixel_ready
                && !result_valid && weight_ready) else begin
            value_errors++;
            $display("[FAIL] %0t: outputs after reset are not at their idle values", $time);
        end

        num_jobs = int'(stim[0]);
        ptr      = 1;
        assert (num_jobs > 0) else begin
            protocol_errors++;
            $display("The stimulus file holds no jobs");
        end
        // Random pixel gaps on every job after the first
        for (int j = 0; j < num_jobs; j++) begin
            run_job(j, j > 0);
        end

        $display("value errors %0d, protocol errors %0d, timeouts %0d",
                 value_errors, protocol_errors, timeouts);
        if (value_errors == 0 && protocol_errors == 0 && timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
